/* core_types_pkg.sv */
package core_types_pkg;

	// machine word, also the width of every operand and result
	typedef logic [31:0] data_t;

	// destination register index
	typedef logic [4:0] reg_id_t;

	// instruction tag assigned at issue, echoed back on retire
	typedef logic [3:0] inst_id_t;

	// multiplier pipeline depth, also its latency in cycles
	localparam int MUL_STAGES = 3;

	// divider iterations, one quotient bit each
	localparam int DIV_STEPS = 32;

	// long writeback channels behind the round-robin arbiter
	// bit 0 lsu, bit 1 mul, bit 2 div
	localparam int WBK_CHN_N = 3;

endpackage

/* dbus_pkg.sv */
package dbus_pkg;

	// access status returned with every lsu result
	typedef enum logic [1:0] {
		DBUS_OK        = 2'b00, // normal completion
		DBUS_UNALIGNED = 2'b01, // low address bits set
		DBUS_BUS_ERR   = 2'b10  // outside the ram window
	} dbus_err_e;

	// private data ram, word organised
	localparam int RAM_WORDS = 64;

	// word index into the ram
	typedef logic [$clog2(RAM_WORDS)-1:0] ram_addr_t;

	// first byte address past the ram
	localparam logic [31:0] RAM_LIMIT = 32'h0000_0100;

endpackage

/* rr_arbiter.sv */
module rr_arbiter #(
	parameter int chn_n = 3 // number of requesters
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [chn_n-1:0] req,   // one bit per channel
	output logic [chn_n-1:0] grant  // one-hot, or zero when idle
);

	logic [chn_n-1:0] ptr;    // one-hot, channel with top priority
	logic [chn_n-1:0] req_hi; // requests at or above the pointer
	logic [chn_n-1:0] gnt_hi; // lowest of req_hi
	logic [chn_n-1:0] gnt_lo; // lowest of all, used on wrap

	// ptr - 1 sets every bit below the pointer
	assign req_hi = req & ~(ptr - 1'b1);

	// x & -x isolates the lowest set bit
	assign gnt_hi = req_hi & (~req_hi + 1'b1);
	assign gnt_lo = req & (~req + 1'b1);

	// search from the pointer first, then wrap around to bit 0
	assign grant = (|req_hi) ? gnt_hi : gnt_lo;

	// pointer moves to the channel after the winner
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr <= {{(chn_n-1){1'b0}}, 1'b1}; // channel 0 first
		end else if (|grant) begin
			ptr <= {grant[chn_n-2:0], grant[chn_n-1]}; // rotate left
		end
	end

endmodule

/* mul_unit.sv */
module mul_unit (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  core_types_pkg::data_t    in_a,
	input  core_types_pkg::data_t    in_b,
	input  core_types_pkg::reg_id_t  in_rd,
	input  core_types_pkg::inst_id_t in_inst_id,
	output logic                     out_valid,
	input  logic                     out_ready,
	output core_types_pkg::data_t    out_data,
	output core_types_pkg::reg_id_t  out_rd,
	output core_types_pkg::inst_id_t out_inst_id
);
	import core_types_pkg::*;

	logic [MUL_STAGES-1:0] stg_vld;             // one valid per stage
	reg_id_t               stg_rd [MUL_STAGES]; // rd travels with the data
	inst_id_t              stg_id [MUL_STAGES];
	logic                  adv;                 // all stages shift together

	// 16x16 partial products, a_hi*b_hi only touches bits 63:32
	data_t       s1_pp, s2_pp, s3_pp;
	logic [15:0] s1_a_lo, s1_a_hi, s1_b_lo, s1_b_hi;
	logic [15:0] s2_a_hi, s2_b_lo;

	// pipe stalls only when the last stage is full and not taken
	assign adv      = ~stg_vld[MUL_STAGES-1] | out_ready;
	assign in_ready = adv;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stg_vld <= '0;
		end else if (adv) begin
			stg_vld <= {stg_vld[MUL_STAGES-2:0], in_valid};
		end
	end

	always_ff @(posedge clk) begin
		if (adv) begin
			s1_pp   <= in_a[15:0] * in_b[15:0]; // lo x lo, full 32 bits
			s1_a_lo <= in_a[15:0];
			s1_a_hi <= in_a[31:16];
			s1_b_lo <= in_b[15:0];
			s1_b_hi <= in_b[31:16];
			s2_pp   <= s1_pp + {s1_a_lo * s1_b_hi, 16'h0000}; // cross term, low half only
			s2_a_hi <= s1_a_hi;
			s2_b_lo <= s1_b_lo;
			s3_pp   <= s2_pp + {s2_a_hi * s2_b_lo, 16'h0000}; // second cross term
			stg_rd[0] <= in_rd;
			stg_id[0] <= in_inst_id;
			for (int i = 1; i < MUL_STAGES; i++) begin
				stg_rd[i] <= stg_rd[i-1];
				stg_id[i] <= stg_id[i-1];
			end
		end
	end

	assign out_valid   = stg_vld[MUL_STAGES-1];
	assign out_data    = s3_pp;
	assign out_rd      = stg_rd[MUL_STAGES-1];
	assign out_inst_id = stg_id[MUL_STAGES-1];

endmodule

/* div_unit.sv */
module div_unit (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  core_types_pkg::data_t    in_a,       // dividend
	input  core_types_pkg::data_t    in_b,       // divisor
	input  core_types_pkg::reg_id_t  in_rd,
	input  core_types_pkg::inst_id_t in_inst_id,
	output logic                     out_valid,
	input  logic                     out_ready,
	output core_types_pkg::data_t    out_data,   // quotient
	output core_types_pkg::reg_id_t  out_rd,
	output core_types_pkg::inst_id_t out_inst_id
);
	import core_types_pkg::*;

	typedef enum logic [1:0] {
		IDLE, // waiting for an operation
		RUN,  // one quotient bit per clock
		DONE  // quotient held until taken
	} div_state_e;

	div_state_e           state;
	logic [DIV_STEPS-1:0] step;   // one-hot, marks the current iteration
	data_t                rem;    // partial remainder
	data_t                quo;    // dividend shifts out, quotient shifts in
	data_t                dvs;    // divisor
	reg_id_t              rd_q;
	inst_id_t             id_q;
	logic [32:0]          rem_sh; // remainder with next dividend bit
	logic [33:0]          trial;  // extra msb is the borrow

	assign rem_sh = {rem, quo[31]};
	assign trial  = {1'b0, rem_sh} - {2'b00, dvs};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			step  <= '0;
		end else begin
			case (state)
				IDLE: if (in_valid) begin
					state <= RUN;
					step  <= {{(DIV_STEPS-1){1'b0}}, 1'b1};
				end
				RUN: begin
					step <= step << 1;
					if (step[DIV_STEPS-1]) state <= DONE; // last bit this clock
				end
				DONE: if (out_ready) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// restoring step, divisor 0 never borrows so the quotient ends all ones
	always_ff @(posedge clk) begin
		if (state == IDLE && in_valid) begin
			rem  <= '0;
			quo  <= in_a;
			dvs  <= in_b;
			rd_q <= in_rd;
			id_q <= in_inst_id;
		end else if (state == RUN) begin
			if (!trial[33]) begin // fits, keep the difference
				rem <= trial[31:0];
				quo <= {quo[30:0], 1'b1};
			end else begin        // restore
				rem <= rem_sh[31:0];
				quo <= {quo[30:0], 1'b0};
			end
		end
	end

	assign in_ready    = (state == IDLE);
	assign out_valid   = (state == DONE);
	assign out_data    = quo;
	assign out_rd      = rd_q;
	assign out_inst_id = id_q;

endmodule

/* lsu_unit.sv */
module lsu_unit (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  logic                     in_store,    // 1 store, 0 load
	input  core_types_pkg::data_t    in_addr,     // byte address
	input  core_types_pkg::data_t    in_wdata,
	input  core_types_pkg::reg_id_t  in_rd,
	input  core_types_pkg::inst_id_t in_inst_id,
	output logic                     out_valid,
	input  logic                     out_ready,
	output dbus_pkg::dbus_err_e      out_err,
	output core_types_pkg::data_t    out_addr,
	output logic                     out_store,
	output core_types_pkg::data_t    out_data,    // load data
	output core_types_pkg::reg_id_t  out_rd,
	output core_types_pkg::inst_id_t out_inst_id
);
	import core_types_pkg::*;
	import dbus_pkg::*;

	data_t     ram [RAM_WORDS]; // private data ram
	ram_addr_t idx;             // word index of the access
	dbus_err_e err;             // status of the incoming access
	logic      acc;             // access accepted this clock
	logic      ram_ok;          // access may touch the ram

	// result register empty or being drained
	assign in_ready = ~out_valid | out_ready;
	assign acc      = in_valid & in_ready;
	assign idx      = ram_addr_t'(in_addr[31:2]);

	// range check wins over alignment
	always_comb begin
		if (in_addr >= RAM_LIMIT) begin
			err = DBUS_BUS_ERR;
		end else if (in_addr[1:0] != 2'b00) begin
			err = DBUS_UNALIGNED;
		end else begin
			err = DBUS_OK;
		end
	end

	assign ram_ok = (err == DBUS_OK);

	always_ff @(posedge clk) begin
		if (acc && in_store && ram_ok) begin
			ram[idx] <= in_wdata; // bad accesses leave the ram alone
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	// result payload, loaded once per accepted access
	always_ff @(posedge clk) begin
		if (acc) begin
			out_err     <= err;
			out_addr    <= in_addr;
			out_store   <= in_store;
			out_data    <= ram_ok ? ram[idx] : '0; // old word on a store
			out_rd      <= in_rd;
			out_inst_id <= in_inst_id;
		end
	end

endmodule

/* wbk_unit.sv */
module wbk_unit (
	input  logic                     clk,
	input  logic                     rst_n,
	// alu, single cycle result
	input  logic                     alu_valid,
	output logic                     alu_ready,
	input  core_types_pkg::data_t    alu_res,
	input  core_types_pkg::reg_id_t  alu_rd,
	input  logic                     alu_rd_vld,
	input  core_types_pkg::inst_id_t alu_inst_id,
	// lsu result
	input  logic                     lsu_wbk_valid,
	output logic                     lsu_wbk_ready,
	input  dbus_pkg::dbus_err_e      lsu_wbk_err,
	input  core_types_pkg::data_t    lsu_wbk_addr,
	input  logic                     lsu_wbk_store,
	input  core_types_pkg::data_t    lsu_wbk_data,
	input  core_types_pkg::reg_id_t  lsu_wbk_rd,
	input  core_types_pkg::inst_id_t lsu_wbk_inst_id,
	// multiplier result
	input  logic                     mul_wbk_valid,
	output logic                     mul_wbk_ready,
	input  core_types_pkg::data_t    mul_wbk_data,
	input  core_types_pkg::reg_id_t  mul_wbk_rd,
	input  core_types_pkg::inst_id_t mul_wbk_inst_id,
	// divider result
	input  logic                     div_wbk_valid,
	output logic                     div_wbk_ready,
	input  core_types_pkg::data_t    div_wbk_data,
	input  core_types_pkg::reg_id_t  div_wbk_rd,
	input  core_types_pkg::inst_id_t div_wbk_inst_id,
	// lsu exception
	output logic                     lsu_expt_valid,
	input  logic                     lsu_expt_ready,
	output core_types_pkg::data_t    lsu_expt_addr,
	output logic                     lsu_expt_store,
	// register file write port
	output logic                     reg_file_wen,
	output core_types_pkg::reg_id_t  reg_file_waddr,
	output core_types_pkg::data_t    reg_file_din,
	// retire
	output logic                     inst_retire,
	output core_types_pkg::inst_id_t inst_retire_id
);
	import core_types_pkg::*;
	import dbus_pkg::*;

	logic                 expt_req;   // bus error waiting at the lsu
	logic [WBK_CHN_N-1:0] long_req;   // {div, mul, lsu}
	logic [WBK_CHN_N-1:0] long_gnt;
	logic                 lsu_gnt, mul_gnt, div_gnt, alu_gnt;
	logic                 lsu_retire; // normal grant or taken exception
	logic                 lsu_ld_ok;  // good load, writes rd

	assign expt_req = lsu_wbk_valid & (lsu_wbk_err == DBUS_BUS_ERR);

	// exception blocks every other request
	assign long_req = {div_wbk_valid, mul_wbk_valid, lsu_wbk_valid} & {WBK_CHN_N{~expt_req}};

	rr_arbiter #(
		.chn_n (WBK_CHN_N)
	) i_arb (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (long_req),
		.grant (long_gnt)
	);

	assign lsu_gnt = long_gnt[0];
	assign mul_gnt = long_gnt[1];
	assign div_gnt = long_gnt[2];

	// alu only gets the port when nothing else wants it
	assign alu_ready = ~expt_req & ~(|long_req);
	assign alu_gnt   = alu_valid & alu_ready;

	assign lsu_expt_valid = expt_req;
	assign lsu_expt_addr  = lsu_wbk_addr;
	assign lsu_expt_store = lsu_wbk_store;

	assign lsu_wbk_ready = lsu_gnt | (expt_req & lsu_expt_ready);
	assign mul_wbk_ready = mul_gnt;
	assign div_wbk_ready = div_gnt;

	assign lsu_retire = lsu_wbk_valid & lsu_wbk_ready;
	assign lsu_ld_ok  = (lsu_wbk_err == DBUS_OK) & ~lsu_wbk_store;

	// stores, unaligned loads and exceptions retire without a write
	assign reg_file_wen = (lsu_gnt & lsu_ld_ok) | mul_gnt | div_gnt | (alu_gnt & alu_rd_vld);

	// grants are one-hot, so and-or steering is enough
	assign reg_file_waddr = ({$bits(reg_id_t){lsu_gnt}} & lsu_wbk_rd) |
		({$bits(reg_id_t){mul_gnt}} & mul_wbk_rd) |
		({$bits(reg_id_t){div_gnt}} & div_wbk_rd) |
		({$bits(reg_id_t){alu_gnt}} & alu_rd);
	assign reg_file_din = ({$bits(data_t){lsu_gnt}} & lsu_wbk_data) |
		({$bits(data_t){mul_gnt}} & mul_wbk_data) |
		({$bits(data_t){div_gnt}} & div_wbk_data) |
		({$bits(data_t){alu_gnt}} & alu_res);

	assign inst_retire    = lsu_retire | mul_gnt | div_gnt | alu_gnt; // never more than one
	assign inst_retire_id = ({$bits(inst_id_t){lsu_retire}} & lsu_wbk_inst_id) |
		({$bits(inst_id_t){mul_gnt}} & mul_wbk_inst_id) |
		({$bits(inst_id_t){div_gnt}} & div_wbk_inst_id) |
		({$bits(inst_id_t){alu_gnt}} & alu_inst_id);

endmodule

/* exu_top.sv */
module exu_top (
	input  logic                     clk,
	input  logic                     rst_n,
	// alu issue
	input  logic                     alu_valid,
	output logic                     alu_ready,
	input  core_types_pkg::data_t    alu_res,
	input  core_types_pkg::reg_id_t  alu_rd,
	input  logic                     alu_rd_vld,
	input  core_types_pkg::inst_id_t alu_inst_id,
	// multiply issue
	input  logic                     mul_valid,
	output logic                     mul_ready,
	input  core_types_pkg::data_t    mul_a,
	input  core_types_pkg::data_t    mul_b,
	input  core_types_pkg::reg_id_t  mul_rd,
	input  core_types_pkg::inst_id_t mul_inst_id,
	// divide issue
	input  logic                     div_valid,
	output logic                     div_ready,
	input  core_types_pkg::data_t    div_a,
	input  core_types_pkg::data_t    div_b,
	input  core_types_pkg::reg_id_t  div_rd,
	input  core_types_pkg::inst_id_t div_inst_id,
	// load/store issue
	input  logic                     lsu_valid,
	output logic                     lsu_ready,
	input  logic                     lsu_store,
	input  core_types_pkg::data_t    lsu_addr,
	input  core_types_pkg::data_t    lsu_wdata,
	input  core_types_pkg::reg_id_t  lsu_rd,
	input  core_types_pkg::inst_id_t lsu_inst_id,
	// lsu exception
	output logic                     lsu_expt_valid,
	input  logic                     lsu_expt_ready,
	output core_types_pkg::data_t    lsu_expt_addr,
	output logic                     lsu_expt_store,
	// register file write port and retire
	output logic                     reg_file_wen,
	output core_types_pkg::reg_id_t  reg_file_waddr,
	output core_types_pkg::data_t    reg_file_din,
	output logic                     inst_retire,
	output core_types_pkg::inst_id_t inst_retire_id
);
	import core_types_pkg::*;
	import dbus_pkg::*;

	logic      mul_wbk_valid, mul_wbk_ready;
	data_t     mul_wbk_data;
	reg_id_t   mul_wbk_rd;
	inst_id_t  mul_wbk_inst_id;
	logic      div_wbk_valid, div_wbk_ready;
	data_t     div_wbk_data;
	reg_id_t   div_wbk_rd;
	inst_id_t  div_wbk_inst_id;
	logic      lsu_wbk_valid, lsu_wbk_ready, lsu_wbk_store;
	dbus_err_e lsu_wbk_err;
	data_t     lsu_wbk_addr, lsu_wbk_data;
	reg_id_t   lsu_wbk_rd;
	inst_id_t  lsu_wbk_inst_id;

	mul_unit i_mul (
		.clk (clk), .rst_n (rst_n),
		.in_valid (mul_valid), .in_ready (mul_ready), .in_a (mul_a), .in_b (mul_b),
		.in_rd (mul_rd), .in_inst_id (mul_inst_id),
		.out_valid (mul_wbk_valid), .out_ready (mul_wbk_ready), .out_data (mul_wbk_data),
		.out_rd (mul_wbk_rd), .out_inst_id (mul_wbk_inst_id)
	);

	div_unit i_div (
		.clk (clk), .rst_n (rst_n),
		.in_valid (div_valid), .in_ready (div_ready), .in_a (div_a), .in_b (div_b),
		.in_rd (div_rd), .in_inst_id (div_inst_id),
		.out_valid (div_wbk_valid), .out_ready (div_wbk_ready), .out_data (div_wbk_data),
		.out_rd (div_wbk_rd), .out_inst_id (div_wbk_inst_id)
	);

	lsu_unit i_lsu (
		.clk (clk), .rst_n (rst_n),
		.in_valid (lsu_valid), .in_ready (lsu_ready), .in_store (lsu_store),
		.in_addr (lsu_addr), .in_wdata (lsu_wdata), .in_rd (lsu_rd), .in_inst_id (lsu_inst_id),
		.out_valid (lsu_wbk_valid), .out_ready (lsu_wbk_ready), .out_err (lsu_wbk_err),
		.out_addr (lsu_wbk_addr), .out_store (lsu_wbk_store), .out_data (lsu_wbk_data),
		.out_rd (lsu_wbk_rd), .out_inst_id (lsu_wbk_inst_id)
	);

	wbk_unit i_wbk (
		.clk (clk), .rst_n (rst_n),
		.alu_valid (alu_valid), .alu_ready (alu_ready), .alu_res (alu_res),
		.alu_rd (alu_rd), .alu_rd_vld (alu_rd_vld), .alu_inst_id (alu_inst_id),
		.lsu_wbk_valid (lsu_wbk_valid), .lsu_wbk_ready (lsu_wbk_ready),
		.lsu_wbk_err (lsu_wbk_err), .lsu_wbk_addr (lsu_wbk_addr),
		.lsu_wbk_store (lsu_wbk_store), .lsu_wbk_data (lsu_wbk_data),
		.lsu_wbk_rd (lsu_wbk_rd), .lsu_wbk_inst_id (lsu_wbk_inst_id),
		.mul_wbk_valid (mul_wbk_valid), .mul_wbk_ready (mul_wbk_ready),
		.mul_wbk_data (mul_wbk_data), .mul_wbk_rd (mul_wbk_rd),
		.mul_wbk_inst_id (mul_wbk_inst_id),
		.div_wbk_valid (div_wbk_valid), .div_wbk_ready (div_wbk_ready),
		.div_wbk_data (div_wbk_data), .div_wbk_rd (div_wbk_rd),
		.div_wbk_inst_id (div_wbk_inst_id),
		.lsu_expt_valid (lsu_expt_valid), .lsu_expt_ready (lsu_expt_ready),
		.lsu_expt_addr (lsu_expt_addr), .lsu_expt_store (lsu_expt_store),
		.reg_file_wen (reg_file_wen), .reg_file_waddr (reg_file_waddr),
		.reg_file_din (reg_file_din),
		.inst_retire (inst_retire), .inst_retire_id (inst_retire_id)
	);

endmodule

/* tb_exu_top.sv */
module tb_exu_top;
	import core_types_pkg::*;

	// sum of the six tests with the divider at 33 cycles per op plus margin
	localparam int TIMEOUT_CYC = 4000;

	logic     clk;
	logic     rst_n;
	logic     alu_valid, alu_ready, alu_rd_vld;
	data_t    alu_res;
	reg_id_t  alu_rd;
	inst_id_t alu_inst_id;
	logic     mul_valid, mul_ready;
	data_t    mul_a, mul_b;
	reg_id_t  mul_rd;
	inst_id_t mul_inst_id;
	logic     div_valid, div_ready;
	data_t    div_a, div_b;
	reg_id_t  div_rd;
	inst_id_t div_inst_id;
	logic     lsu_valid, lsu_ready, lsu_store;
	data_t    lsu_addr, lsu_wdata;
	reg_id_t  lsu_rd;
	inst_id_t lsu_inst_id;
	logic     lsu_expt_valid, lsu_expt_ready, lsu_expt_store;
	data_t    lsu_expt_addr;
	logic     reg_file_wen, inst_retire;
	reg_id_t  reg_file_waddr;
	data_t    reg_file_din;
	inst_id_t inst_retire_id;

	// scoreboard with one slot per instruction id
	logic     exp_pend [16];
	logic     exp_wen  [16];
	reg_id_t  exp_rd   [16];
	data_t    exp_data [16];
	inst_id_t ret_q [$];   // retired ids in retire order
	int       ret_cyc [$]; // cycle of each retire
	int       err_cnt, pass_cnt, fail_cnt;
	int       cyc = 0;
	data_t    seed;
	data_t    mem_word;    // word stored at 0x40 and loaded again under contention

	exu_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc++;
		if (cyc >= TIMEOUT_CYC) begin
			$display("timeout, run went past %0d cycles", TIMEOUT_CYC);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic data_t lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic check_data(input string name, input data_t want, input data_t got);
		if (want !== got) begin
			err_cnt++;
			$display("MISMATCH %s expected %h got %h", name, want, got);
		end
	endtask

	task automatic check_reg(input string name, input reg_id_t want, input reg_id_t got);
		if (want !== got) begin
			err_cnt++;
			$display("MISMATCH %s expected %h got %h", name, want, got);
		end
	endtask

	task automatic check_id(input string name, input inst_id_t want, input inst_id_t got);
		if (want !== got) begin
			err_cnt++;
			$display("MISMATCH %s expected %h got %h", name, want, got);
		end
	endtask

	task automatic check_bit(input string name, input logic want, input logic got);
		if (want !== got) begin
			err_cnt++;
			$display("MISMATCH %s expected %h got %h", name, want, got);
		end
	endtask

	// retire monitor samples mid-cycle where everything has settled
	always @(negedge clk) begin
		if (rst_n && reg_file_wen && !inst_retire) begin
			err_cnt++;
			$display("register write without a retire at cycle %0d", cyc);
		end
		if (rst_n && inst_retire) begin
			if (!exp_pend[inst_retire_id]) begin
				err_cnt++;
				$display("unexpected retire of id %h at cycle %0d", inst_retire_id, cyc);
			end else begin
				check_bit("reg_file_wen", exp_wen[inst_retire_id], reg_file_wen);
				if (exp_wen[inst_retire_id]) begin
					check_reg("reg_file_waddr", exp_rd[inst_retire_id], reg_file_waddr);
					check_data("reg_file_din", exp_data[inst_retire_id], reg_file_din);
				end
				exp_pend[inst_retire_id] = 1'b0;
			end
			ret_q.push_back(inst_retire_id);
			ret_cyc.push_back(cyc);
		end
	end

	function automatic int pending();
		int n;
		n = 0;
		for (int i = 0; i < 16; i++) n += exp_pend[i];
		return n;
	endfunction

	task automatic expect_retire(input inst_id_t id, input logic wen, input reg_id_t rd,
		input data_t data);
		if (exp_pend[id]) begin
			err_cnt++;
			$display("id %h reissued before it retired", id);
		end
		exp_pend[id] = 1'b1;
		exp_wen[id]  = wen;
		exp_rd[id]   = rd;
		exp_data[id] = data;
	endtask

	// anything still pending after max_cyc is a lost retire
	task automatic wait_retires(input int max_cyc);
		int n;
		n = 0;
		while (pending() != 0 && n < max_cyc) begin
			@(posedge clk);
			#1;
			n++;
		end
		for (int i = 0; i < 16; i++) begin
			if (exp_pend[i]) begin
				err_cnt++;
				$display("id %0h never retired within %0d cycles", i, max_cyc);
				exp_pend[i] = 1'b0;
			end
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		if (err_cnt == err_start) begin
			pass_cnt++;
			$display("%s: pass", name);
		end else begin
			fail_cnt++;
			$display("%s: fail, %0d errors", name, err_cnt - err_start);
		end
	endtask

	// issue tasks start and end 1 unit after a rising edge
	task automatic issue_alu(input data_t res, input reg_id_t rd, input logic rd_vld,
		input inst_id_t id);
		expect_retire(id, rd_vld, rd, res);
		alu_valid   = 1'b1;
		alu_res     = res;
		alu_rd      = rd;
		alu_rd_vld  = rd_vld;
		alu_inst_id = id;
		@(negedge clk);
		while (!alu_ready) @(negedge clk);
		@(posedge clk);
		#1;
		alu_valid = 1'b0;
	endtask

	task automatic issue_mul(input data_t a, input data_t b, input reg_id_t rd,
		input inst_id_t id);
		data_t prod;
		prod = a * b; // low word only
		expect_retire(id, 1'b1, rd, prod);
		mul_valid   = 1'b1;
		mul_a       = a;
		mul_b       = b;
		mul_rd      = rd;
		mul_inst_id = id;
		@(negedge clk);
		while (!mul_ready) @(negedge clk);
		@(posedge clk);
		#1;
		mul_valid = 1'b0;
	endtask

	task automatic issue_div(input data_t a, input data_t b, input reg_id_t rd,
		input inst_id_t id);
		data_t quo;
		quo = (b == 0) ? 32'hffff_ffff : a / b; // riscv divide by zero rule
		expect_retire(id, 1'b1, rd, quo);
		div_valid   = 1'b1;
		div_a       = a;
		div_b       = b;
		div_rd      = rd;
		div_inst_id = id;
		@(negedge clk);
		while (!div_ready) @(negedge clk);
		@(posedge clk);
		#1;
		div_valid = 1'b0;
	endtask

	task automatic issue_lsu(input logic store, input data_t addr, input data_t wdata,
		input reg_id_t rd, input inst_id_t id, input logic wen, input data_t rdata);
		expect_retire(id, wen, rd, rdata);
		lsu_valid   = 1'b1;
		lsu_store   = store;
		lsu_addr    = addr;
		lsu_wdata   = wdata;
		lsu_rd      = rd;
		lsu_inst_id = id;
		@(negedge clk);
		while (!lsu_ready) @(negedge clk);
		@(posedge clk);
		#1;
		lsu_valid = 1'b0;
	endtask

	task automatic alu_retire();
		int e;
		e = err_cnt;
		issue_alu(lcg_next(), 5'd5, 1'b1, 4'd1);
		issue_alu(lcg_next(), 5'd6, 1'b0, 4'd2); // no rd so retire only
		wait_retires(10);
		report_test("alu retire", e);
	endtask

	task automatic mul_order();
		int e;
		e = err_cnt;
		ret_q.delete();
		for (int i = 0; i < 8; i++) begin
			issue_mul(lcg_next(), lcg_next(), reg_id_t'(8 + i), inst_id_t'(i));
		end
		wait_retires(MUL_STAGES + 10);
		if (ret_q.size() != 8) begin
			err_cnt++;
			$display("expected 8 multiply retires, saw %0d", ret_q.size());
		end else begin
			for (int i = 0; i < 8; i++) check_id("inst_retire_id", inst_id_t'(i), ret_q[i]);
		end
		report_test("mul order", e);
	endtask

	task automatic div_quotient();
		int    e;
		data_t a, b;
		e = err_cnt;
		for (int i = 0; i < 4; i++) begin
			a = lcg_next();
			b = (i == 3) ? '0 : lcg_next() >> (8 * i); // smaller divisors and finally zero
			issue_div(a, b, reg_id_t'(16 + i), inst_id_t'(i));
			// busy until the quotient has retired
			while (exp_pend[i]) begin
				@(negedge clk);
				if (div_ready) begin
					err_cnt++;
					$display("divider ready again before id %0h retired", i);
				end
				@(posedge clk);
			end
			#1;
		end
		wait_retires(5);
		report_test("div quotient", e);
	endtask

	task automatic lsu_store_load();
		int e;
		e = err_cnt;
		mem_word = lcg_next();
		issue_lsu(1'b1, 32'h40, mem_word, 5'd0, 4'd3, 1'b0, '0);
		issue_lsu(1'b0, 32'h40, '0, 5'd10, 4'd4, 1'b1, mem_word);
		// misaligned store and load hit the same word index
		issue_lsu(1'b1, 32'h41, ~mem_word, 5'd11, 4'd5, 1'b0, '0);
		issue_lsu(1'b0, 32'h42, '0, 5'd12, 4'd6, 1'b0, '0);
		issue_lsu(1'b0, 32'h40, '0, 5'd13, 4'd7, 1'b1, mem_word); // still intact
		wait_retires(10);
		report_test("lsu store load", e);
	endtask

	task automatic bus_error();
		int    e, n;
		data_t addr;
		logic  st;
		e = err_cnt;
		for (int i = 0; i < 2; i++) begin
			st   = (i == 1);
			addr = st ? 32'h8000_0ffc : 32'h0000_0100; // load at the limit and store far above
			issue_lsu(st, addr, lcg_next(), 5'd1, inst_id_t'(8 + i), 1'b0, '0);
			n = 0;
			@(negedge clk);
			while (!lsu_expt_valid && n < 5) begin
				@(negedge clk);
				n++;
			end
			if (!lsu_expt_valid) begin
				err_cnt++;
				$display("no exception raised for address %h", addr);
			end
			check_data("lsu_expt_addr", addr, lsu_expt_addr);
			check_bit("lsu_expt_store", st, lsu_expt_store);
			repeat (6) begin
				if (inst_retire) begin
					err_cnt++;
					$display("retire while the exception waits for ready");
				end
				@(negedge clk);
			end
			@(posedge clk);
			#1;
			lsu_expt_ready = 1'b1;
			wait_retires(4);
			lsu_expt_ready = 1'b0;
		end
		report_test("bus error", e);
	endtask

	// a pending exception holds every unit back until all results wait together
	task automatic port_contention();
		int    e;
		data_t v;
		logic  l, a;
		e = err_cnt;
		ret_q.delete();
		ret_cyc.delete();
		issue_div(lcg_next(), lcg_next() >> 20, 5'd20, 4'd8);
		issue_lsu(1'b0, 32'h0000_0200, '0, 5'd21, 4'd9, 1'b0, '0); // becomes the blocker
		for (int i = 0; i < 3; i++) begin
			issue_mul(lcg_next(), lcg_next(), reg_id_t'(22 + i), inst_id_t'(10 + i));
		end
		expect_retire(4'd13, 1'b1, 5'd25, mem_word);
		lsu_valid   = 1'b1;
		lsu_store   = 1'b0;
		lsu_addr    = 32'h40;
		lsu_rd      = 5'd25;
		lsu_inst_id = 4'd13;
		v = lcg_next();
		expect_retire(4'd14, 1'b1, 5'd26, v);
		alu_valid   = 1'b1;
		alu_res     = v;
		alu_rd      = 5'd26;
		alu_rd_vld  = 1'b1;
		alu_inst_id = 4'd14;
		repeat (DIV_STEPS + 3) begin // long enough for the quotient to be ready
			@(negedge clk);
			if (inst_retire) begin
				err_cnt++;
				$display("retire while the exception waits for ready");
			end
			if (mul_ready) begin // first multiply sits in the last stage ungranted
				err_cnt++;
				$display("multiplier ready while its full output stage is stalled");
			end
			@(posedge clk);
			#1;
		end
		lsu_expt_ready = 1'b1;
		while (lsu_valid || alu_valid) begin
			@(negedge clk);
			l = lsu_ready;
			a = alu_ready;
			@(posedge clk);
			#1;
			if (l) lsu_valid = 1'b0;
			if (a) alu_valid = 1'b0;
		end
		lsu_expt_ready = 1'b0;
		wait_retires(10);
		if (ret_q.size() != 7) begin
			err_cnt++;
			$display("expected 7 retires under contention, saw %0d", ret_q.size());
		end else begin
			check_id("inst_retire_id", 4'd9, ret_q[0]);  // exception first
			check_id("inst_retire_id", 4'd14, ret_q[6]); // alu after every long result
			for (int i = 1; i < 7; i++) begin
				if (ret_cyc[i] != ret_cyc[i-1] + 1) begin
					err_cnt++;
					$display("idle cycle between retires %0d and %0d", i - 1, i);
				end
			end
		end
		report_test("port contention", e);
	endtask

	initial begin
		seed     = 32'h96f8_ce2e;
		err_cnt  = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		mem_word = '0;
		{alu_valid, alu_rd_vld, alu_res, alu_rd, alu_inst_id} = '0;
		{mul_valid, mul_a, mul_b, mul_rd, mul_inst_id} = '0;
		{div_valid, div_a, div_b, div_rd, div_inst_id} = '0;
		{lsu_valid, lsu_store, lsu_addr, lsu_wdata, lsu_rd, lsu_inst_id} = '0;
		lsu_expt_ready = 1'b0;
		for (int i = 0; i < 16; i++) exp_pend[i] = 1'b0;
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		alu_retire();
		mul_order();
		div_quotient();
		lsu_store_load();
		bus_error();
		port_contention();
		$display("tests pass %0d, fail %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* files.f */
core_types_pkg.sv
dbus_pkg.sv
rr_arbiter.sv
mul_unit.sv
div_unit.sv
lsu_unit.sv
wbk_unit.sv
exu_top.sv
tb_exu_top.sv

/* Bender.yml */
package:
  name: exu_top

sources:
  - core_types_pkg.sv
  - dbus_pkg.sv
  - rr_arbiter.sv
  - mul_unit.sv
  - div_unit.sv
  - lsu_unit.sv
  - wbk_unit.sv
  - exu_top.sv
  - target: test
    files:
      - tb_exu_top.sv
